//--- Bender.yml
package:
  name: loop_filter

sources:
  - files:
      - hw/loopFilterPkg.sv
      - hw/loopRegs.sv
      - hw/errorConditioner.sv
      - hw/leadPath.sv
      - hw/lagIntegrator.sv
      - hw/filterCombiner.sv
      - hw/loopFilter.sv
  - target: test
    files:
      - testbench/loopFilterTb.sv

//--- hw/errorConditioner.sv
`default_nettype none

module errorConditioner #(
    parameter int errorBits = loopFilterPkg::errorWidth
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clkEn,
    input  logic                        zeroError,
    input  logic                        invertError,
    input  logic signed [errorBits-1:0] error,
    output logic signed [errorBits-1:0] loopError
);

    localparam logic signed [errorBits-1:0] minCode = {1'b1, {(errorBits-1){1'b0}}};
    localparam logic signed [errorBits-1:0] maxCode = {1'b0, {(errorBits-1){1'b1}}};

    logic signed [errorBits-1:0] negError;

    // most negative code has no positive twin, pin it to max
    assign negError = (error == minCode) ? maxCode : -error;

    always_ff @(posedge clk) begin
        if (reset) begin
            loopError <= '0;
        end else if (zeroError) begin
            loopError <= '0; // holds zero even between steps
        end else if (clkEn) begin
            loopError <= invertError ? negError : error;
        end
    end

endmodule

`default_nettype wire

//--- hw/filterCombiner.sv
`default_nettype none

module filterCombiner #(
    parameter int dataBits = loopFilterPkg::dataWidth
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clkEn,
    input  logic signed [dataBits-1:0] lagAccum,
    input  logic signed [dataBits-1:0] leadTerm,
    output logic signed [dataBits-1:0] loopFreq
);

    localparam logic signed [dataBits-1:0] maxFreq = {1'b0, {(dataBits-1){1'b1}}};
    localparam logic signed [dataBits-1:0] minFreq = {1'b1, {(dataBits-1){1'b0}}};

    logic signed [dataBits:0]   sum;
    logic signed [dataBits-1:0] satSum;

    assign sum = {lagAccum[dataBits-1], lagAccum} + {leadTerm[dataBits-1], leadTerm};

    // top two bits disagree only on overflow, then the sign picks the rail
    always_comb begin
        if (sum[dataBits] != sum[dataBits-1]) begin
            satSum = sum[dataBits] ? minFreq : maxFreq;
        end else begin
            satSum = sum[dataBits-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loopFreq <= '0;
        end else if (clkEn) begin
            loopFreq <= satSum;
        end
    end

endmodule

`default_nettype wire

//--- hw/lagIntegrator.sv
`default_nettype none

module lagIntegrator #(
    parameter int errorBits = loopFilterPkg::errorWidth,
    parameter int dataBits  = loopFilterPkg::dataWidth,
    parameter int gainBits  = loopFilterPkg::gainWidth
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clkEn,
    input  logic                        clearAccum,
    input  logic        [gainBits-1:0]  lagCode,
    input  logic signed [errorBits-1:0] loopError,
    input  logic        [dataBits-2:0]  limit,
    output logic signed [dataBits-1:0]  lagAccum,
    output logic                        satPos,
    output logic                        satNeg
);

    import loopFilterPkg::*;

    logic signed [dataBits-1:0] lagError;
    logic signed [dataBits:0]   sum;      // one bit of headroom
    logic signed [dataBits:0]   upperLimit;
    logic signed [dataBits:0]   lowerLimit;

    // scaled error, first step of the integral branch
    always_ff @(posedge clk) begin
        if (reset) begin
            lagError <= '0;
        end else if (clkEn) begin
            lagError <= gainShift(loopError, lagCode);
        end
    end

    assign sum        = {lagAccum[dataBits-1], lagAccum} + {lagError[dataBits-1], lagError};
    assign upperLimit = {2'b00, limit};
    assign lowerLimit = -upperLimit;

    always_ff @(posedge clk) begin
        if (reset) begin
            lagAccum <= '0;
            satPos   <= 1'b0;
            satNeg   <= 1'b0;
        end else if (clearAccum) begin
            lagAccum <= '0; // flags wait for the next step
        end else if (clkEn) begin
            if (sum > upperLimit) begin
                lagAccum <= upperLimit[dataBits-1:0];
                satPos   <= 1'b1;
                satNeg   <= 1'b0;
            end else if (sum < lowerLimit) begin
                lagAccum <= lowerLimit[dataBits-1:0];
                satPos   <= 1'b0;
                satNeg   <= 1'b1;
            end else begin
                // inside the window, the narrow value is exact
                lagAccum <= sum[dataBits-1:0];
                satPos   <= 1'b0;
                satNeg   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/leadPath.sv
`default_nettype none

module leadPath #(
    parameter int errorBits = loopFilterPkg::errorWidth,
    parameter int dataBits  = loopFilterPkg::dataWidth,
    parameter int gainBits  = loopFilterPkg::gainWidth
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clkEn,
    input  logic        [gainBits-1:0]  leadCode,
    input  logic signed [errorBits-1:0] loopError,
    output logic signed [dataBits-1:0]  leadTerm
);

    import loopFilterPkg::*;

    // proportional term, one step behind loopError
    always_ff @(posedge clk) begin
        if (reset) begin
            leadTerm <= '0;
        end else if (clkEn) begin
            leadTerm <= gainShift(loopError, leadCode);
        end
    end

endmodule

`default_nettype wire

//--- hw/loopFilter.sv
`default_nettype none

module loopFilter #(
    parameter int errorBits = loopFilterPkg::errorWidth,
    parameter int dataBits  = loopFilterPkg::dataWidth,
    parameter int addrBits  = loopFilterPkg::addrWidth,
    parameter int gainBits  = loopFilterPkg::gainWidth
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clkEn,
    input  logic                        cs,
    input  logic                        wr0,
    input  logic                        wr1,
    input  logic                        wr2,
    input  logic                        wr3,
    input  logic        [addrBits-1:0]  addr,
    input  logic        [dataBits-1:0]  din,
    output logic        [dataBits-1:0]  dout,
    input  logic signed [errorBits-1:0] error,
    output logic signed [dataBits-1:0]  loopFreq,
    output logic                        satPos,
    output logic                        satNeg,
    output logic                        ctrl2,
    output logic                        ctrl4,
    output logic        [15:0]          lockCount,
    output logic        [11:0]          syncThreshold
);

    logic                        invertError;
    logic                        zeroError;
    logic                        clearAccum;
    logic        [gainBits-1:0]  leadCode;
    logic        [gainBits-1:0]  lagCode;
    logic        [dataBits-2:0]  limit;
    logic signed [errorBits-1:0] loopError;
    logic signed [dataBits-1:0]  leadTerm;
    logic signed [dataBits-1:0]  lagAccum;

    loopRegs #(
        .addrBits(addrBits),
        .dataBits(dataBits),
        .gainBits(gainBits)
    ) regs (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .wr0(wr0),
        .wr1(wr1),
        .wr2(wr2),
        .wr3(wr3),
        .addr(addr),
        .din(din),
        .lagAccum(lagAccum),
        .dout(dout),
        .invertError(invertError),
        .zeroError(zeroError),
        .ctrl2(ctrl2),
        .ctrl4(ctrl4),
        .clearAccum(clearAccum),
        .leadCode(leadCode),
        .lagCode(lagCode),
        .limit(limit),
        .lockCount(lockCount),
        .syncThreshold(syncThreshold)
    );

    errorConditioner #(
        .errorBits(errorBits)
    ) conditioner (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .zeroError(zeroError),
        .invertError(invertError),
        .error(error),
        .loopError(loopError)
    );

    // proportional and integral branches run side by side
    leadPath #(
        .errorBits(errorBits),
        .dataBits(dataBits),
        .gainBits(gainBits)
    ) lead (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .leadCode(leadCode),
        .loopError(loopError),
        .leadTerm(leadTerm)
    );

    lagIntegrator #(
        .errorBits(errorBits),
        .dataBits(dataBits),
        .gainBits(gainBits)
    ) lag (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .clearAccum(clearAccum),
        .lagCode(lagCode),
        .loopError(loopError),
        .limit(limit),
        .lagAccum(lagAccum),
        .satPos(satPos),
        .satNeg(satNeg)
    );

    filterCombiner #(
        .dataBits(dataBits)
    ) combiner (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .lagAccum(lagAccum),
        .leadTerm(leadTerm),
        .loopFreq(loopFreq)
    );

endmodule

`default_nettype wire

//--- hw/loopFilterPkg.sv
`default_nettype none

package loopFilterPkg;

    localparam int errorWidth = 12; // phase error from the detector
    localparam int dataWidth  = 32; // bus data, accumulator and loopFreq
    localparam int addrWidth  = 13;
    localparam int gainWidth  = 5;

    // gain code that passes the error through unscaled
    localparam int unityCode = 11;

    // word addresses of the register bank
    typedef enum logic [addrWidth-1:0] {
        regControl = 13'd0,
        regGains   = 13'd1,
        regLimit   = 13'd2,
        regSync    = 13'd3,
        regAccum   = 13'd4
    } regAddr_e;

    // error * 2**(code - 11), code 0 turns the path off
    function automatic logic signed [dataWidth-1:0] gainShift(
        input logic signed [errorWidth-1:0] err,
        input logic        [gainWidth-1:0]  code
    );
        logic signed [dataWidth-1:0] wide;
        wide = err; // sign extends
        if (code == '0) begin
            return '0;
        end else if (int'(code) < unityCode) begin
            return wide >>> (unityCode - int'(code)); // fractional gain
        end else begin
            return wide <<< (int'(code) - unityCode);
        end
    endfunction

endpackage

`default_nettype wire

//--- hw/loopRegs.sv
`default_nettype none

module loopRegs #(
    parameter int addrBits = loopFilterPkg::addrWidth,
    parameter int dataBits = loopFilterPkg::dataWidth,
    parameter int gainBits = loopFilterPkg::gainWidth
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cs,
    input  logic                       wr0,
    input  logic                       wr1,
    input  logic                       wr2,
    input  logic                       wr3,
    input  logic        [addrBits-1:0] addr,
    input  logic        [dataBits-1:0] din,
    input  logic signed [dataBits-1:0] lagAccum,
    output logic        [dataBits-1:0] dout,
    output logic                       invertError,
    output logic                       zeroError,
    output logic                       ctrl2,
    output logic                       ctrl4,
    output logic                       clearAccum,
    output logic        [gainBits-1:0] leadCode,
    output logic        [gainBits-1:0] lagCode,
    output logic        [dataBits-2:0] limit,
    output logic        [15:0]         lockCount,
    output logic        [11:0]         syncThreshold
);

    import loopFilterPkg::*;

    logic selControl;
    logic selGains;
    logic selLimit;
    logic selSync;

    assign selControl = cs && (addr == regControl);
    assign selGains   = cs && (addr == regGains);
    assign selLimit   = cs && (addr == regLimit);
    assign selSync    = cs && (addr == regSync);

    always_ff @(posedge clk) begin
        if (reset) begin
            invertError   <= 1'b0;
            zeroError     <= 1'b0;
            ctrl2         <= 1'b0;
            ctrl4         <= 1'b0;
            clearAccum    <= 1'b0;
            leadCode      <= '0;
            lagCode       <= '0;
            limit         <= '0;
            lockCount     <= '0;
            syncThreshold <= '0;
        end else begin
            clearAccum <= 1'b0; // self clearing
            if (selControl && wr0) begin
                invertError <= din[0];
                zeroError   <= din[1];
                ctrl2       <= din[2];
                clearAccum  <= din[3]; // one clk pulse per write of 1
                ctrl4       <= din[4];
            end
            if (selGains && wr0) leadCode <= din[gainBits-1:0];
            if (selGains && wr1) lagCode  <= din[8 +: gainBits];
            // limit, msb of the word is not stored
            if (selLimit && wr0) limit[7:0]             <= din[7:0];
            if (selLimit && wr1) limit[15:8]            <= din[15:8];
            if (selLimit && wr2) limit[23:16]           <= din[23:16];
            if (selLimit && wr3) limit[dataBits-2:24]   <= din[dataBits-2:24];
            if (selSync && wr0)  lockCount[7:0]         <= din[7:0];
            if (selSync && wr1)  lockCount[15:8]        <= din[15:8];
            if (selSync && wr2)  syncThreshold[7:0]     <= din[23:16];
            if (selSync && wr3)  syncThreshold[11:8]    <= din[27:24];
        end
    end

    // read mux, unmapped words read zero
    always_comb begin
        dout = '0;
        case (addr)
            regControl: dout[4:0] = {ctrl4, 1'b0, ctrl2, zeroError, invertError};
            regGains: begin
                dout[gainBits-1:0] = leadCode;
                dout[8 +: gainBits] = lagCode;
            end
            regLimit: dout[dataBits-2:0] = limit;
            regSync: begin
                dout[15:0]  = lockCount;
                dout[27:16] = syncThreshold;
            end
            regAccum: dout = lagAccum; // live value
            default:  dout = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- testbench/loopFilterCases.txt
# W name addr mask data / R name addr expected (all hex)
# S name gap count error expFreq satPos satNeg (gap count flags decimal, error expFreq hex)
W ctrlSet 0 1 00000014
R ctrlRead 0 00000014
W ctrlClear 0 1 00000008
R ctrlReadClr 0 00000000
W syncAll 3 f 0abc1234
R syncRead 3 0abc1234
W syncTop 3 8 05ffffff
R syncReadTop 3 05bc1234
W limitLane1 2 2 ffffaaff
W limitLane3 2 8 ff000000
R limitRead 2 7f00aa00
W gainsAll 1 3 ffffffff
R gainsRead 1 00001f1f
R unmapped5 5 00000000
R unmapped1fff 1fff 00000000
W leadCode1 1 3 00000001
S lead1Pos 0 4 400 00000001 0 0
S lead1Neg 0 4 fff ffffffff 0 0
W leadCode0 1 1 00000000
S lead0 0 4 7ff 00000000 0 0
W leadCode11 1 1 0000000b
S lead11Neg 0 4 800 fffff800 0 0
W leadCode31 1 1 0000001f
S lead31Pos 0 4 7ff 7ff00000 0 0
S lead31Neg 0 4 c00 c0000000 0 0
W gainsOff 1 3 00000000
S flush 0 4 000 00000000 0 0
W lagCode12 1 3 00000c00
S lagRun 0 6 010 00000060 0 0
R accumMid 4 00000080
S lagDrain 0 4 000 000000c0 0 0
R accumDrain 4 000000c0
W limitSmall 2 f 00000100
S clampPos 0 8 064 00000100 1 0
S clampNeg 0 8 f9c ffffff00 0 1
S clampRelease 0 4 001 ffffff02 0 0
W gainsInvert 1 3 0000000b
W ctrlInvert 0 1 00000009
S invertMin 0 4 800 00000801 0 0
S invertPos 0 4 064 ffffff9e 0 0
W gainsZero 1 3 00000c00
W ctrlZero 0 1 0000000a
S zeroRun 0 6 100 00000000 0 0
R accumZero 4 00000000
W ctrlRun 0 1 00000000
S preClear 0 5 010 00000040 0 0
W clearMid 0 1 00000008
R accumCleared 4 00000000
S postClear 0 4 010 00000060 0 0
S gapRun 1 6 ff0 00000060 0 0
S gapDrain 1 4 000 00000000 0 0

//--- testbench/loopFilterTb.sv
`default_nettype none

module loopFilterTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int maxCases = 80;
    localparam longint freqMax = 64'sh7FFF_FFFF;
    localparam longint freqMin = -64'sh8000_0000;

    logic        clk = 1'b0;
    logic        reset;
    logic        clkEn;
    logic        cs;
    logic        wr0;
    logic        wr1;
    logic        wr2;
    logic        wr3;
    logic [12:0] addr;
    logic [31:0] din;
    logic [31:0] dout;
    logic [11:0] error;
    logic [31:0] loopFreq;
    logic        satPos;
    logic        satNeg;
    logic        ctrl2;
    logic        ctrl4;
    logic [15:0] lockCount;
    logic [11:0] syncThreshold;

    // parsed case file
    logic [7:0]      kinds [0:maxCases-1];
    logic [8*20-1:0] names [0:maxCases-1];
    logic [31:0]     field [0:maxCases-1][0:5];
    int numCases = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycleLimit = 0;

    // step model of the filter
    longint mLoopError = 0;
    longint mLead = 0;
    longint mLagErr = 0;
    longint mAccum = 0;
    longint mFreq = 0;
    logic   mPos = 1'b0;
    logic   mNeg = 1'b0;
    logic [31:0] mCtrl = '0;
    logic [31:0] mGains = '0;
    logic [31:0] mLimitReg = '0;
    logic [31:0] mSync = '0;

    loopFilter DUT (
        .clk(clk), .reset(reset), .clkEn(clkEn), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout), .error(error),
        .loopFreq(loopFreq), .satPos(satPos), .satNeg(satNeg),
        .ctrl2(ctrl2), .ctrl4(ctrl4), .lockCount(lockCount),
        .syncThreshold(syncThreshold)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // error times 2**(code-11) rounded toward minus infinity for small codes
    function automatic longint scaleError(input longint err, input int code);
        longint divisor;
        longint q;
        if (code == 0) return 0;
        if (code >= 11) return err * (longint'(1) << (code - 11));
        divisor = longint'(1) << (11 - code);
        q = err / divisor;
        if (err < 0 && q * divisor != err) q = q - 1;
        return q;
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    task automatic checkValue(input logic [8*20-1:0] name, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH %0s %0s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    // one clkEn step where every stage sees the values from before the edge
    task automatic modelStep(input longint e);
        longint lim;
        longint sum;
        longint cond;
        lim = mLimitReg[30:0];
        if (mCtrl[1]) cond = 0;
        else if (mCtrl[0]) cond = (e == -2048) ? 2047 : -e;
        else cond = e;
        sum = mAccum + mLead;
        mFreq = (sum > freqMax) ? freqMax : ((sum < freqMin) ? freqMin : sum);
        sum = mAccum + mLagErr;
        mPos = sum > lim;
        mNeg = sum < -lim;
        mAccum = mPos ? lim : (mNeg ? -lim : sum);
        mLagErr = scaleError(mLoopError, mGains[12:8]);
        mLead = scaleError(mLoopError, mGains[4:0]);
        mLoopError = cond;
    endtask

    task automatic busWrite(input int idx);
        logic [31:0] a;
        logic [31:0] mask;
        logic [31:0] data;
        a = field[idx][0];
        mask = field[idx][1];
        data = field[idx][2];
        @(negedge clk);
        cs = 1'b1;
        addr = a[12:0];
        din = data;
        {wr3, wr2, wr1, wr0} = mask[3:0];
        @(negedge clk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0;
        case (a)
            0: begin
                mCtrl = mergeBytes(mCtrl, data, mask[3:0]);
                if (mask[0] && data[3]) mAccum = 0; // clear pulse
                if (mCtrl[1]) mLoopError = 0;
            end
            1: mGains = mergeBytes(mGains, data, mask[3:0]);
            2: mLimitReg = mergeBytes(mLimitReg, data, mask[3:0]);
            3: mSync = mergeBytes(mSync, data, mask[3:0]);
            default: ;
        endcase
        checkValue(names[idx], "ctrl2", mCtrl[2], ctrl2);
        checkValue(names[idx], "ctrl4", mCtrl[4], ctrl4);
        checkValue(names[idx], "lockCount", mSync[15:0], lockCount);
        checkValue(names[idx], "syncThreshold", mSync[27:16], syncThreshold);
    endtask

    task automatic busRead(input int idx);
        @(negedge clk);
        cs = 1'b1;
        addr = field[idx][0][12:0];
        @(negedge clk);
        checkValue(names[idx], "dout", field[idx][1], dout);
        if (field[idx][0] == 4) checkValue(names[idx], "accum model", mAccum[31:0], dout);
        cs = 1'b0;
    endtask

    task automatic runSamples(input int idx);
        int gap;
        longint e;
        e = $signed(field[idx][2][11:0]);
        for (int k = 0; k < field[idx][1]; k++) begin
            gap = (field[idx][0] != 0) ? $urandom_range(3, 0) : 0;
            repeat (gap) begin
                @(negedge clk);
                clkEn = 1'b0;
            end
            @(negedge clk);
            clkEn = 1'b1;
            error = field[idx][2][11:0];
            modelStep(e);
        end
        @(negedge clk);
        clkEn = 1'b0;
        checkValue(names[idx], "loopFreq", field[idx][3], loopFreq);
        checkValue(names[idx], "loopFreq model", mFreq[31:0], loopFreq);
        checkValue(names[idx], "satPos", field[idx][4], satPos);
        checkValue(names[idx], "satNeg", field[idx][5], satNeg);
        checkValue(names[idx], "sat model", {mPos, mNeg}, {satPos, satNeg});
    endtask

    initial begin
        int fd;
        int code;
        int totalOps;
        logic [8*8-1:0]   tok;
        logic [8*256-1:0] lineBuf;
        logic [8*20-1:0]  nm;
        logic [31:0] v0, v1, v2, v3, v4, v5;
        reset = 1'b1;
        clkEn = 1'b0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0;
        addr = '0;
        din = '0;
        error = '0;
        totalOps = 0;
        void'($urandom(11882));
        fd = $fopen("testbench/loopFilterCases.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/loopFilterCases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && numCases < maxCases) begin
                code = $fscanf(fd, " %s", tok);
                if (code == 1 && tok == "#") begin
                    code = $fgets(lineBuf, fd); // column notes
                end else if (code == 1) begin
                    v3 = 0;
                    v4 = 0;
                    v5 = 0;
                    if (tok == "W") code = $fscanf(fd, " %s %h %h %h", nm, v0, v1, v2);
                    else if (tok == "R") code = $fscanf(fd, " %s %h %h", nm, v0, v1);
                    else if (tok == "S")
                        code = $fscanf(fd, " %s %d %d %h %h %d %d", nm, v0, v1, v2, v3, v4, v5);
                    else begin
                        $display("unknown line kind %0s in the case file", tok);
                        errors++;
                    end
                    kinds[numCases] = tok[7:0];
                    names[numCases] = nm;
                    field[numCases][0] = v0;
                    field[numCases][1] = v1;
                    field[numCases][2] = v2;
                    field[numCases][3] = v3;
                    field[numCases][4] = v4;
                    field[numCases][5] = v5;
                    totalOps += (tok == "S") ? v1 : 1;
                    numCases++;
                end
            end
            $fclose(fd);
        end
        if (numCases == 0) begin
            $display("no cases were read from the case file");
            errors++;
        end
        cycleLimit = 20 * totalOps + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < numCases; i++) begin
            case (kinds[i])
                "W": busWrite(i);
                "R": busRead(i);
                "S": runSamples(i);
                default: ;
            endcase
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/loopFilterPkg.sv
hw/loopRegs.sv
hw/errorConditioner.sv
hw/leadPath.sv
hw/lagIntegrator.sv
hw/filterCombiner.sv
hw/loopFilter.sv
testbench/loopFilterTb.sv
